/* verilog/game_defs.svh */
////////////////////////////////////////
// Game constants
// Screen, player and enemy sprite table
////////////////////////////////////////
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

`define SCREEN_W 8'd160
`define SCREEN_H 7'd120

`define PLAYER_W 4'd3
`define PLAYER_COLOUR 3'd7

`define N_ENEMIES 3'd5

// Enemy start positions
`define ENEMY_X0 8'd80
`define ENEMY_Y0 7'd60
`define ENEMY_X1 8'd100
`define ENEMY_Y1 7'd50
`define ENEMY_X2 8'd30
`define ENEMY_Y2 7'd100
`define ENEMY_X3 8'd50
`define ENEMY_Y3 7'd100
`define ENEMY_X4 8'd80
`define ENEMY_Y4 7'd20

`define ENEMY_W0 4'd3
`define ENEMY_W1 4'd5
`define ENEMY_W2 4'd7
`define ENEMY_W3 4'd13
`define ENEMY_W4 4'd11

// Enemy k is drawn in colour k+1
`define ENEMY_C0 3'd1
`define ENEMY_C1 3'd2
`define ENEMY_C2 3'd3
`define ENEMY_C3 3'd4
`define ENEMY_C4 3'd5

// Bit k enables enemy k
`define LEVEL1_MASK 5'b00011
`define LEVEL2_MASK 5'b00111
`define LEVEL3_MASK 5'b11000
`define LEVEL4_MASK 5'b11111

`endif

/* verilog/game_pkg.sv */
////////////////////////////////////////
// Game types
// Pixel fields and FSM state encodings
////////////////////////////////////////
package game_pkg;

    typedef logic [7:0] pix_x_t;
    typedef logic [6:0] pix_y_t;
    typedef logic [2:0] colour_t;

    // Sprite 0 is the player, 1 to 5 the enemies
    typedef logic [2:0] sprite_idx_t;

    typedef enum logic [2:0] {
        LEVEL_SELECT,
        LOAD_LEVEL,
        LEVEL_PAUSE,
        PLAY_START,
        PLAY,
        PAUSING,
        GAME_OVER
    } game_state_t;

    typedef enum logic [1:0] {
        IDLE,
        ERASE,
        DRAW,
        OVER
    } draw_state_t;

endpackage

/* verilog/raster_if.sv */
////////////////////////////////////////
// Raster link
// Rectangle request and scan position
////////////////////////////////////////
`timescale 1ns/100ps

interface raster_if;
    import game_pkg::*;

    logic start;            // Load a new rectangle
    pix_x_t x0;
    pix_y_t y0;
    logic [7:0] side;       // Width, also height
    pix_x_t x;
    pix_y_t y;
    logic busy;
    logic last;             // Final pixel of the scan

    modport painter (output start, x0, y0, side, input x, y, busy, last);
    modport scanner (input start, x0, y0, side, output x, y, busy, last);

endinterface

/* verilog/game_fsm.sv */
////////////////////////////////////////
// Game flow FSM
// Level select, play, pause, game over
////////////////////////////////////////
`timescale 1ns/100ps

module game_fsm (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 go,
    input  logic                 player_hit,
    output game_pkg::game_state_t state,
    output logic                 level_start
);
    import game_pkg::*;

    game_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            LEVEL_SELECT: if (go) state_next = LOAD_LEVEL;
            LOAD_LEVEL:   if (!go) state_next = LEVEL_PAUSE;
            LEVEL_PAUSE:  if (go) state_next = PLAY_START;
            PLAY_START:   if (!go) state_next = PLAY;
            PLAY: begin
                if (go)
                    state_next = PAUSING;
                else if (player_hit)
                    state_next = GAME_OVER;
            end
            PAUSING:      if (!go) state_next = LEVEL_PAUSE;
            GAME_OVER:    if (go) state_next = LOAD_LEVEL;
            default:      state_next = LEVEL_SELECT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= LEVEL_SELECT;
            level_start <= 1'b0;
        end else begin
            state <= state_next;
            // High for the first cycle in LOAD_LEVEL only
            level_start <= (state_next == LOAD_LEVEL) && (state != LOAD_LEVEL);
        end
    end

endmodule

/* verilog/draw_fsm.sv */
////////////////////////////////////////
// Drawing FSM
// Orders clear, sprite pass, game over
////////////////////////////////////////
`timescale 1ns/100ps

module draw_fsm (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  level_start,
    input  logic                  redraw,
    input  game_pkg::game_state_t game_state,
    input  logic                  done,
    output game_pkg::draw_state_t draw_state
);
    import game_pkg::*;

    draw_state_t state_next;

    always_comb begin
        state_next = draw_state;
        case (draw_state)
            IDLE: begin
                if (level_start)
                    state_next = DRAW;      // Fresh level, screen already clear
                else if (game_state == GAME_OVER)
                    state_next = OVER;
                else if (redraw && game_state == PLAY)
                    state_next = ERASE;
            end
            ERASE: if (done) state_next = DRAW;
            DRAW:  if (done) state_next = IDLE;
            OVER:  if (level_start) state_next = ERASE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            draw_state <= IDLE;
        else
            draw_state <= state_next;
    end

endmodule

/* verilog/raster_counter.sv */
////////////////////////////////////////
// Raster scanner
// Walks a square row by row
////////////////////////////////////////
`timescale 1ns/100ps
`include "game_defs.svh"

module raster_counter (
    input logic      clk,
    input logic      resetn,
    raster_if.scanner ras
);
    import game_pkg::*;

    pix_x_t x_lo;
    pix_x_t x_hi;
    logic [7:0] y_hi;
    logic row_end;
    logic col_end;

    assign row_end = (ras.x == x_hi);
    // Rows also stop at the screen bottom, so a 160 wide square clears the screen
    assign col_end = ({1'b0, ras.y} == y_hi) || (ras.y == `SCREEN_H - 7'd1);
    assign ras.last = ras.busy && row_end && col_end;

    always_ff @(posedge clk) begin
        if (!resetn)
            ras.busy <= 1'b0;
        else if (ras.start)
            ras.busy <= 1'b1;
        else if (ras.last)
            ras.busy <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (ras.start) begin
            x_lo <= ras.x0;
            x_hi <= ras.x0 + ras.side - 8'd1;
            y_hi <= {1'b0, ras.y0} + ras.side - 8'd1;
            ras.x <= ras.x0;
            ras.y <= ras.y0;
        end else if (ras.busy && !ras.last) begin
            if (row_end) begin
                ras.x <= x_lo;              // Wrap to next row
                ras.y <= ras.y + 7'd1;
            end else begin
                ras.x <= ras.x + 8'd1;
            end
        end
    end

endmodule

/* verilog/sprite_table.sv */
////////////////////////////////////////
// Sprite table
// Level mask and per-sprite geometry
////////////////////////////////////////
`timescale 1ns/100ps
`include "game_defs.svh"

module sprite_table (
    input  logic                  clk,
    input  logic [2:0]            level,
    input  logic                  level_select,
    input  game_pkg::pix_x_t      player_x,
    input  game_pkg::pix_y_t      player_y,
    input  game_pkg::sprite_idx_t idx,
    output game_pkg::pix_x_t      sx,
    output game_pkg::pix_y_t      sy,
    output logic [3:0]            side,
    output game_pkg::colour_t     colour,
    output logic                  enabled
);
    import game_pkg::*;

    logic [4:0] mask;

    always_ff @(posedge clk) begin
        if (level_select) begin
            case (level)
                3'd2:    mask <= `LEVEL2_MASK;
                3'd3:    mask <= `LEVEL3_MASK;
                3'd4:    mask <= `LEVEL4_MASK;
                default: mask <= `LEVEL1_MASK;
            endcase
        end
    end

    always_comb begin
        sx = '0;
        sy = '0;
        side = '0;
        colour = '0;
        enabled = 1'b0;
        case (idx)
            3'd0: begin
                sx = player_x;
                sy = player_y;
                side = `PLAYER_W;
                colour = `PLAYER_COLOUR;
                enabled = 1'b1;             // Player is always drawn
            end
            3'd1: begin
                sx = `ENEMY_X0;
                sy = `ENEMY_Y0;
                side = `ENEMY_W0;
                colour = `ENEMY_C0;
                enabled = mask[0];
            end
            3'd2: begin
                sx = `ENEMY_X1;
                sy = `ENEMY_Y1;
                side = `ENEMY_W1;
                colour = `ENEMY_C1;
                enabled = mask[1];
            end
            3'd3: begin
                sx = `ENEMY_X2;
                sy = `ENEMY_Y2;
                side = `ENEMY_W2;
                colour = `ENEMY_C2;
                enabled = mask[2];
            end
            3'd4: begin
                sx = `ENEMY_X3;
                sy = `ENEMY_Y3;
                side = `ENEMY_W3;
                colour = `ENEMY_C3;
                enabled = mask[3];
            end
            3'd5: begin
                sx = `ENEMY_X4;
                sy = `ENEMY_Y4;
                side = `ENEMY_W4;
                colour = `ENEMY_C4;
                enabled = mask[4];
            end
            default: ;
        endcase
    end

endmodule

/* verilog/frame_painter.sv */
////////////////////////////////////////
// Frame painter
// Sequences sprite rasters into pixels
////////////////////////////////////////
`timescale 1ns/100ps
`include "game_defs.svh"

module frame_painter (
    input  logic                  clk,
    input  logic                  resetn,
    input  game_pkg::draw_state_t draw_state,
    output game_pkg::sprite_idx_t idx,
    input  game_pkg::pix_x_t      sx,
    input  game_pkg::pix_y_t      sy,
    input  logic [3:0]            side,
    input  game_pkg::colour_t     colour,
    input  logic                  enabled,
    raster_if.painter             ras,
    output game_pkg::pix_x_t      x,
    output game_pkg::pix_y_t      y,
    output game_pkg::colour_t     pix_colour,
    output logic                  plot,
    output logic                  done
);
    import game_pkg::*;

    draw_state_t prev_state;
    logic entry;
    logic walking;          // Stepping through the sprite list
    logic erasing;

    assign entry = (draw_state != prev_state);
    assign erasing = (draw_state == ERASE);

    // Erase is one full-width square from the origin
    assign ras.start = (entry && erasing) || (walking && !ras.busy && enabled);
    assign ras.x0 = erasing ? '0 : sx;
    assign ras.y0 = erasing ? '0 : sy;
    assign ras.side = erasing ? `SCREEN_W : {4'd0, side};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prev_state <= IDLE;
            walking <= 1'b0;
            idx <= '0;
            done <= 1'b0;
            plot <= 1'b0;
        end else begin
            prev_state <= draw_state;
            done <= 1'b0;
            plot <= ras.busy;
            if (entry) begin
                idx <= '0;
                walking <= (draw_state == DRAW);
            end else if (walking) begin
                if (ras.last) begin
                    idx <= idx + 3'd1;
                end else if (!ras.busy && !enabled) begin
                    if (idx == `N_ENEMIES + 3'd1) begin
                        walking <= 1'b0;
                        done <= 1'b1;
                    end else begin
                        idx <= idx + 3'd1;  // Skip disabled enemy
                    end
                end
            end else if (erasing && ras.last) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        x <= ras.x;
        y <= ras.y;
        pix_colour <= erasing ? '0 : colour;
    end

endmodule

/* verilog/seg7_decoder.sv */
////////////////////////////////////////
// Seven-segment decoder
// Hex digit, active-low segments
////////////////////////////////////////
`timescale 1ns/100ps

module seg7_decoder (
    input  logic [3:0] digit,
    output logic [6:0] segments
);

    always_comb begin
        case (digit)
            4'h0: segments = 7'b1000000;
            4'h1: segments = 7'b1111001;
            4'h2: segments = 7'b0100100;
            4'h3: segments = 7'b0110000;
            4'h4: segments = 7'b0011001;
            4'h5: segments = 7'b0010010;
            4'h6: segments = 7'b0000010;
            4'h7: segments = 7'b1111000;
            4'h8: segments = 7'b0000000;
            4'h9: segments = 7'b0011000;
            4'ha: segments = 7'b0001000;
            4'hb: segments = 7'b0000011;
            4'hc: segments = 7'b1000110;
            4'hd: segments = 7'b0100001;
            4'he: segments = 7'b0000110;
            default: segments = 7'b0001110;
        endcase
    end

endmodule

/* verilog/game_top.sv */
////////////////////////////////////////
// Game core top level
// FSMs, sprite painter, level display
////////////////////////////////////////
`timescale 1ns/100ps

module game_top (
    input  logic       clk,
    input  logic       resetn,
    input  logic       go,
    input  logic       redraw,
    input  logic       player_hit,
    input  logic [2:0] level,
    input  logic [7:0] player_x,
    input  logic [6:0] player_y,
    output logic [7:0] x,
    output logic [6:0] y,
    output logic [2:0] colour,
    output logic       plot,
    output logic       game_over,
    output logic [6:0] hex0
);
    import game_pkg::*;

    game_state_t game_state;
    draw_state_t draw_state;
    logic level_start;
    logic done;
    sprite_idx_t idx;
    pix_x_t sx;
    pix_y_t sy;
    logic [3:0] side;
    colour_t sprite_colour;
    logic enabled;

    raster_if ras ();

    assign game_over = (game_state == GAME_OVER);

    game_fsm u_game_fsm (
        .clk         (clk),
        .resetn      (resetn),
        .go          (go),
        .player_hit  (player_hit),
        .state       (game_state),
        .level_start (level_start)
    );

    draw_fsm u_draw_fsm (
        .clk         (clk),
        .resetn      (resetn),
        .level_start (level_start),
        .redraw      (redraw),
        .game_state  (game_state),
        .done        (done),
        .draw_state  (draw_state)
    );

    raster_counter u_raster (
        .clk    (clk),
        .resetn (resetn),
        .ras    (ras.scanner)
    );

    sprite_table u_sprites (
        .clk          (clk),
        .level        (level),
        .level_select (game_state == LEVEL_SELECT),   // Mask follows the switches here
        .player_x     (player_x),
        .player_y     (player_y),
        .idx          (idx),
        .sx           (sx),
        .sy           (sy),
        .side         (side),
        .colour       (sprite_colour),
        .enabled      (enabled)
    );

    frame_painter u_painter (
        .clk        (clk),
        .resetn     (resetn),
        .draw_state (draw_state),
        .idx        (idx),
        .sx         (sx),
        .sy         (sy),
        .side       (side),
        .colour     (sprite_colour),
        .enabled    (enabled),
        .ras        (ras.painter),
        .x          (x),
        .y          (y),
        .pix_colour (colour),
        .plot       (plot),
        .done       (done)
    );

    seg7_decoder u_hex0 (
        .digit    ({1'b0, level}),
        .segments (hex0)
    );

endmodule

/* bench/tb_game_top.sv */
////////////////////////////////////////
// Game core testbench
// Replays the cases file, checks pixels
////////////////////////////////////////
`timescale 1ns/100ps
`include "game_defs.svh"

module tb_game_top;
    import game_pkg::*;

    localparam int MAX_CASES = 16;
    localparam int CASE_CYCLES = 30000;   // Watchdog budget per case
    localparam int QUIET_CYCLES = 20;

    typedef struct packed {
        pix_x_t  x;
        pix_y_t  y;
        colour_t c;
    } pixel_t;

    logic clk;
    logic resetn;
    logic go;
    logic redraw;
    logic player_hit;
    logic [2:0] level;
    pix_x_t player_x;
    pix_y_t player_y;
    pix_x_t x;
    pix_y_t y;
    colour_t colour;
    logic plot;
    logic game_over;
    logic [6:0] hex0;

    logic [7:0] case_mem [0:4*MAX_CASES-1];
    pixel_t exp_q [$];
    pixel_t want;
    int errors;
    int case_errors;
    int unsigned watchdog_cycles;

    pix_x_t enemy_x [0:4] = '{`ENEMY_X0, `ENEMY_X1, `ENEMY_X2, `ENEMY_X3, `ENEMY_X4};
    pix_y_t enemy_y [0:4] = '{`ENEMY_Y0, `ENEMY_Y1, `ENEMY_Y2, `ENEMY_Y3, `ENEMY_Y4};
    logic [3:0] enemy_w [0:4] = '{`ENEMY_W0, `ENEMY_W1, `ENEMY_W2, `ENEMY_W3, `ENEMY_W4};

    game_top uut (
        .clk        (clk),
        .resetn     (resetn),
        .go         (go),
        .redraw     (redraw),
        .player_hit (player_hit),
        .level      (level),
        .player_x   (player_x),
        .player_y   (player_y),
        .x          (x),
        .y          (y),
        .colour     (colour),
        .plot       (plot),
        .game_over  (game_over),
        .hex0       (hex0)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic record_error();
        errors++;
        case_errors++;
    endtask

    task automatic check_x(input string name, input pix_x_t got, input pix_x_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            record_error();
        end
    endtask

    task automatic check_y(input string name, input pix_y_t got, input pix_y_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            record_error();
        end
    endtask

    task automatic check_colour(input string name, input colour_t got, input colour_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            record_error();
        end
    endtask

    task automatic check_segments(input string name, input logic [6:0] got,
                                  input logic [6:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
            record_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
            record_error();
        end
    endtask

    // Active-low, segment a in bit 0
    function automatic logic [6:0] seg_pattern(input logic [3:0] digit);
        case (digit)
            4'd0: return 7'b1000000;
            4'd1: return 7'b1111001;
            4'd2: return 7'b0100100;
            4'd3: return 7'b0110000;
            4'd4: return 7'b0011001;
            4'd5: return 7'b0010010;
            4'd6: return 7'b0000010;
            4'd7: return 7'b1111000;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic logic [4:0] level_mask(input logic [2:0] lvl);
        case (lvl)
            3'd2: return `LEVEL2_MASK;
            3'd3: return `LEVEL3_MASK;
            3'd4: return `LEVEL4_MASK;
            default: return `LEVEL1_MASK;
        endcase
    endfunction

    task automatic push_rect(input pix_x_t x0, input pix_y_t y0, input int w, input int h,
                             input colour_t c);
        pixel_t p;
        for (int row = 0; row < h; row++) begin
            for (int col = 0; col < w; col++) begin
                p.x = pix_x_t'(int'(x0) + col);
                p.y = pix_y_t'(int'(y0) + row);
                p.c = c;
                exp_q.push_back(p);
            end
        end
    endtask

    // Player first, then enabled enemies in index order
    task automatic push_sprite_pass(input logic [2:0] lvl, input pix_x_t px, input pix_y_t py);
        logic [4:0] mask;
        mask = level_mask(lvl);
        push_rect(px, py, int'(`PLAYER_W), int'(`PLAYER_W), `PLAYER_COLOUR);
        for (int k = 0; k < int'(`N_ENEMIES); k++) begin
            if (mask[k])
                push_rect(enemy_x[k], enemy_y[k], int'(enemy_w[k]), int'(enemy_w[k]),
                          colour_t'(k + 1));
        end
    endtask

    task automatic push_erase();
        push_rect('0, '0, int'(`SCREEN_W), int'(`SCREEN_H), 3'd0);
    endtask

    // Outputs settle after the rising edge, so sample on the falling one
    always @(negedge clk) begin
        if (resetn && plot) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected plot at %0t of pixel (%0d,%0d) after the pass ended",
                         $time, x, y);
                record_error();
            end else begin
                want = exp_q.pop_front();
                check_x("x", x, want.x);
                check_y("y", y, want.y);
                check_colour("colour", colour, want.c);
            end
        end
    end

    task automatic reset_dut(input logic [2:0] lvl, input pix_x_t px, input pix_y_t py);
        @(negedge clk);
        resetn = 1'b0;
        go = 1'b0;
        redraw = 1'b0;
        player_hit = 1'b0;
        level = lvl;
        player_x = px;
        player_y = py;
        exp_q.delete();
        repeat (10) @(negedge clk);
        resetn = 1'b1;
    endtask

    task automatic pulse_inputs(input logic g, input logic r, input logic h);
        @(negedge clk);
        go = g;
        redraw = r;
        player_hit = h;
        @(negedge clk);
        go = 1'b0;
        redraw = 1'b0;
        player_hit = 1'b0;
    endtask

    // All expected pixels seen, then no stray plots
    task automatic wait_drain();
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (QUIET_CYCLES) @(negedge clk);
    endtask

    task automatic load_level(input logic [2:0] lvl, input pix_x_t px, input pix_y_t py);
        push_sprite_pass(lvl, px, py);
        pulse_inputs(1'b1, 1'b0, 1'b0);
        wait_drain();
    endtask

    task automatic start_play();
        pulse_inputs(1'b1, 1'b0, 1'b0);
        repeat (2) @(negedge clk);
    endtask

    task automatic run_case(input int kind, input logic [2:0] lvl, input pix_x_t px,
                            input pix_y_t py);
        reset_dut(lvl, px, py);
        case (kind)
            1: begin
                repeat (2) @(negedge clk);
                check_flag("plot", plot, 1'b0);
                check_flag("game_over", game_over, 1'b0);
                check_segments("hex0", hex0, seg_pattern({1'b0, lvl}));
            end
            2: load_level(lvl, px, py);
            3: begin
                load_level(lvl, px, py);
                start_play();
                push_erase();
                push_sprite_pass(lvl, px, py);
                pulse_inputs(1'b0, 1'b1, 1'b0);
                wait_drain();
            end
            4: begin
                load_level(lvl, px, py);
                start_play();
                start_play();                       // Pause
                pulse_inputs(1'b0, 1'b0, 1'b1);
                repeat (2) @(negedge clk);
                check_flag("game_over", game_over, 1'b0);
                pulse_inputs(1'b0, 1'b1, 1'b0);     // Must plot nothing
                wait_drain();
            end
            5: begin
                load_level(lvl, px, py);
                start_play();
                start_play();
                start_play();                       // Resume
                level = lvl + 3'd1;                 // Mask stays latched
                pulse_inputs(1'b0, 1'b0, 1'b1);
                repeat (2) @(negedge clk);
                check_flag("game_over", game_over, 1'b1);
                push_erase();
                push_sprite_pass(lvl, px, py);
                pulse_inputs(1'b1, 1'b0, 1'b0);
                check_flag("game_over", game_over, 1'b0);
                wait_drain();
            end
            default: begin
                $display("Unknown test kind %0d in the cases file", kind);
                record_error();
            end
        endcase
    endtask

    initial begin
        repeat (1) @(posedge clk);
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT stopped producing pixels", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        int n_cases;
        int passed;
        int kind;
        resetn = 1'b0;
        go = 1'b0;
        redraw = 1'b0;
        player_hit = 1'b0;
        level = 3'd0;
        player_x = '0;
        player_y = '0;
        errors = 0;
        passed = 0;
        watchdog_cycles = 0;
        $readmemh("bench/game_cases.txt", case_mem);
        n_cases = 0;
        while (n_cases < MAX_CASES && case_mem[4 * n_cases] != 8'h00)
            n_cases++;
        if (n_cases == 0) begin
            $display("No test cases were read from bench/game_cases.txt");
            errors++;
        end
        watchdog_cycles = n_cases * CASE_CYCLES;
        for (int i = 0; i < n_cases; i++) begin
            case_errors = 0;
            kind = int'(case_mem[4 * i]);
            run_case(kind, case_mem[4 * i + 1][2:0], case_mem[4 * i + 2],
                     case_mem[4 * i + 3][6:0]);
            if (case_errors == 0)
                passed++;
            $display("Case %0d kind %0d level %0d: %s (%0d errors)", i, kind,
                     case_mem[4 * i + 1], (case_errors == 0) ? "pass" : "fail", case_errors);
        end
        $display("%0d cases run, %0d passed, %0d errors", n_cases, passed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* bench/game_cases.txt */
// kind level player_x player_y, all hex
// kind 1 reset, 2 level load, 3 play redraw, 4 pause, 5 game over, 0 ends the list
1 1 0a 0a
1 4 00 00
1 6 20 20
2 1 0a 14
2 2 4f 3b
2 3 9d 75
2 4 00 00
3 2 20 30
3 5 10 10
4 3 40 40
5 4 50 60
0 0 00 00

/* project.f */
+incdir+verilog
verilog/game_pkg.sv
verilog/raster_if.sv
verilog/game_fsm.sv
verilog/draw_fsm.sv
verilog/raster_counter.sv
verilog/sprite_table.sv
verilog/frame_painter.sv
verilog/seg7_decoder.sv
verilog/game_top.sv
bench/tb_game_top.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the game core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --top-module tb_game_top -f project.f -o sim_game \
    > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_game > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
    exit 1
fi
exit 0
